// ==== ddr_test_pkg.sv ====
package ddr_test_pkg;

	// bus widths
	localparam int ADDR_WIDTH        = 32;
	localparam int NARROW_DATA_WIDTH = 32;
	localparam int WIDE_DATA_WIDTH   = 128;
	// beats per generator burst
	localparam int BURST_LEN         = 8;

	// control port byte offsets
	localparam logic [ADDR_WIDTH-1:0] REG_CTRL       = 32'h00;
	localparam logic [ADDR_WIDTH-1:0] REG_BASE       = 32'h04;
	localparam logic [ADDR_WIDTH-1:0] REG_COUNT      = 32'h08;
	localparam logic [ADDR_WIDTH-1:0] REG_SEED       = 32'h0C;
	localparam logic [ADDR_WIDTH-1:0] REG_STATUS     = 32'h10;
	localparam logic [ADDR_WIDTH-1:0] REG_ERRORS     = 32'h14;
	localparam logic [ADDR_WIDTH-1:0] REG_FIRST_FAIL = 32'h18;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// registers to generator
	typedef struct packed {
		logic                  start;
		logic                  do_write;
		logic                  do_verify;
		logic [ADDR_WIDTH-1:0] base;
		logic [31:0]           count;
		logic [31:0]           seed;
	} test_cfg_t;

	// generator to registers
	typedef struct packed {
		logic                  busy;
		logic                  done;
		logic [31:0]           errors;
		logic [ADDR_WIDTH-1:0] first_fail;
	} test_status_t;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [7:0]            len;
		logic [2:0]            size;
	} aw_narrow_t;

	// same layout on the read address channel
	typedef aw_narrow_t ar_narrow_t;

	typedef struct packed {
		logic [NARROW_DATA_WIDTH-1:0]   data;
		logic [NARROW_DATA_WIDTH/8-1:0] strb;
		logic                           last;
	} w_narrow_t;

	typedef struct packed {
		logic [NARROW_DATA_WIDTH-1:0] data;
		logic [1:0]                   resp;
		logic                         last;
	} r_narrow_t;

	typedef struct packed {
		logic [WIDE_DATA_WIDTH-1:0]   data;
		logic [WIDE_DATA_WIDTH/8-1:0] strb;
		logic                         last;
	} w_wide_t;

	typedef struct packed {
		logic [WIDE_DATA_WIDTH-1:0] data;
		logic [1:0]                 resp;
		logic                       last;
	} r_wide_t;

endpackage

// ==== axi_reg_slice.sv ====
`timescale 1ns/1ns

module axi_reg_slice #(
	parameter type payload_t = logic
) (
	input  logic     init_calib_complete,
	input  logic     sys_resetn,
	input  payload_t in,
	input  logic     in_valid,
	output logic     in_ready,
	output payload_t out,
	output logic     out_valid,
	input  logic     out_ready
);
	// second entry catches the beat in flight when out_ready drops
	payload_t skid;
	logic     skid_valid;

	// registered ready, so no combinational path from out_ready
	assign in_ready = !skid_valid;

	always_ff @(posedge init_calib_complete or negedge sys_resetn) begin
		if (!sys_resetn) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
		end else if (!out_valid || out_ready) begin
			// output free: drain skid first, else take the input
			out_valid  <= skid_valid || (in_valid && in_ready);
			skid_valid <= 1'b0;
		end else if (in_valid && in_ready) begin
			// output stalled, park the new beat
			skid_valid <= 1'b1;
		end
	end

	always_ff @(posedge init_calib_complete) begin
		if (!out_valid || out_ready)
			out <= skid_valid ? skid : in;
		if (!skid_valid)
			skid <= in;
	end

endmodule

// ==== ddr_test_regs.sv ====
`timescale 1ns/1ns

module ddr_test_regs (
	input  logic                                init_calib_complete,
	input  logic                                sys_resetn,
	input  logic [ddr_test_pkg::ADDR_WIDTH-1:0] awaddr,
	input  logic                                awvalid,
	output logic                                awready,
	input  logic [31:0]                         wdata,
	input  logic [3:0]                          wstrb,
	input  logic                                wvalid,
	output logic                                wready,
	output logic [1:0]                          bresp,
	output logic                                bvalid,
	input  logic                                bready,
	input  logic [ddr_test_pkg::ADDR_WIDTH-1:0] araddr,
	input  logic                                arvalid,
	output logic                                arready,
	output logic [31:0]                         rdata,
	output logic [1:0]                          rresp,
	output logic                                rvalid,
	input  logic                                rready,
	output ddr_test_pkg::test_cfg_t             cfg,
	input  ddr_test_pkg::test_status_t          status,
	output logic [2:0]                          led
);
	logic [31:0] base;
	logic [31:0] count;
	logic [31:0] seed;
	logic        do_write;
	logic        do_verify;
	logic        start_pulse;
	logic        done;
	logic [31:0] errors;
	logic [31:0] first_fail;
	logic        wr_en;
	logic        wr_ok;

	// byte lane merge for the plain rw registers
	function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (strb[i])
				res[i*8 +: 8] = data[i*8 +: 8];
		end
		return res;
	endfunction

	// aw and w taken together, only with no response pending
	assign wr_en   = awvalid && wvalid && !bvalid;
	assign awready = wr_en;
	assign wready  = wr_en;
	// writable offsets only, status side is read-only
	assign wr_ok   = awaddr inside {ddr_test_pkg::REG_CTRL, ddr_test_pkg::REG_BASE,
			ddr_test_pkg::REG_COUNT, ddr_test_pkg::REG_SEED};
	assign arready = !rvalid;

	always_ff @(posedge init_calib_complete or negedge sys_resetn) begin
		if (!sys_resetn) begin
			base        <= '0;
			count       <= '0;
			seed        <= '0;
			do_write    <= 1'b0;
			do_verify   <= 1'b0;
			start_pulse <= 1'b0;
			done        <= 1'b0;
			errors      <= '0;
			first_fail  <= '0;
			bvalid      <= 1'b0;
			bresp       <= ddr_test_pkg::RESP_OKAY;
			rvalid      <= 1'b0;
			rresp       <= ddr_test_pkg::RESP_OKAY;
			rdata       <= '0;
		end else begin
			start_pulse <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_en) begin
				bvalid <= 1'b1;
				bresp  <= wr_ok ? ddr_test_pkg::RESP_OKAY : ddr_test_pkg::RESP_SLVERR;
				case (awaddr)
					ddr_test_pkg::REG_BASE:  base  <= merge(base, wdata, wstrb);
					ddr_test_pkg::REG_COUNT: count <= merge(count, wdata, wstrb);
					ddr_test_pkg::REG_SEED:  seed  <= merge(seed, wdata, wstrb);
					ddr_test_pkg::REG_CTRL: begin
						// request dropped silently while a run is active
						if (wstrb[0] && !status.busy && !start_pulse) begin
							do_write    <= wdata[0];
							do_verify   <= wdata[1];
							start_pulse <= 1'b1;
						end
					end
					default: ;
				endcase
			end
			// result held until the next run starts
			if (start_pulse)
				done <= 1'b0;
			if (status.done) begin
				done       <= 1'b1;
				errors     <= status.errors;
				first_fail <= status.first_fail;
			end
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (arvalid && arready) begin
				rvalid <= 1'b1;
				rresp  <= ddr_test_pkg::RESP_OKAY;
				case (araddr)
					ddr_test_pkg::REG_CTRL:       rdata <= {30'b0, do_verify, do_write};
					ddr_test_pkg::REG_BASE:       rdata <= base;
					ddr_test_pkg::REG_COUNT:      rdata <= count;
					ddr_test_pkg::REG_SEED:       rdata <= seed;
					ddr_test_pkg::REG_STATUS:     rdata <= {30'b0, done, status.busy};
					ddr_test_pkg::REG_ERRORS:     rdata <= errors;
					ddr_test_pkg::REG_FIRST_FAIL: rdata <= first_fail;
					default: begin
						rdata <= '0;
						rresp <= ddr_test_pkg::RESP_SLVERR;
					end
				endcase
			end
		end
	end

	assign cfg = '{start: start_pulse, do_write: do_write, do_verify: do_verify,
			base: base, count: count, seed: seed};

	// led2 fail, led1 pass, led0 finished
	assign led = {errors != '0, done && errors == '0, done};

endmodule

// ==== ddr_traffic_gen.sv ====
`timescale 1ns/1ns

module ddr_traffic_gen #(
	parameter int BURST_LEN = 8
) (
	input  logic                       init_calib_complete,
	input  logic                       sys_resetn,
	input  ddr_test_pkg::test_cfg_t    cfg,
	output ddr_test_pkg::test_status_t status,
	output ddr_test_pkg::aw_narrow_t   aw,
	output logic                       aw_valid,
	input  logic                       aw_ready,
	output ddr_test_pkg::w_narrow_t    w,
	output logic                       w_valid,
	input  logic                       w_ready,
	input  logic [1:0]                 b_resp,
	input  logic                       b_valid,
	output logic                       b_ready,
	output ddr_test_pkg::ar_narrow_t   ar,
	output logic                       ar_valid,
	input  logic                       ar_ready,
	input  ddr_test_pkg::r_narrow_t    r,
	input  logic                       r_valid,
	output logic                       r_ready
);
	localparam int          BEAT_W      = $clog2(BURST_LEN);
	localparam logic [31:0] BURST_BYTES = 32'(BURST_LEN * 4);

	typedef enum logic [2:0] {S_IDLE, S_AW, S_W, S_B, S_AR, S_R, S_DONE} state_t;

	state_t                              state;
	logic [ddr_test_pkg::ADDR_WIDTH-1:0] burst_addr;
	logic [ddr_test_pkg::ADDR_WIDTH-1:0] beat_addr;
	logic [ddr_test_pkg::ADDR_WIDTH-1:0] base_q;
	logic [31:0]                         words_left;
	logic [31:0]                         count_q;
	logic [31:0]                         seed_q;
	logic                                verify_q;
	logic [BEAT_W-1:0]                   beat;
	logic [31:0]                         pattern;
	logic                                last_burst;
	logic                                rd_fail;

	// expected word is its own byte address xor seed
	assign beat_addr  = burst_addr + {beat, 2'b00};
	assign pattern    = beat_addr ^ seed_q;
	assign last_burst = words_left <= 32'(BURST_LEN);
	assign rd_fail    = r.data != pattern || r.resp != ddr_test_pkg::RESP_OKAY;

	// one burst in flight per direction, fixed 4-byte incr
	assign aw       = '{addr: burst_addr, len: 8'(BURST_LEN - 1), size: 3'd2};
	assign ar       = aw;
	assign aw_valid = state == S_AW;
	assign ar_valid = state == S_AR;
	assign w        = '{data: pattern, strb: '1, last: beat == BEAT_W'(BURST_LEN - 1)};
	assign w_valid  = state == S_W;
	assign b_ready  = state == S_B;
	assign r_ready  = 1'b1;

	// run settings frozen at start
	always_ff @(posedge init_calib_complete) begin
		if (state == S_IDLE && cfg.start) begin
			base_q   <= cfg.base;
			count_q  <= cfg.count;
			seed_q   <= cfg.seed;
			verify_q <= cfg.do_verify;
		end
	end

	always_ff @(posedge init_calib_complete or negedge sys_resetn) begin
		if (!sys_resetn) begin
			state      <= S_IDLE;
			status     <= '0;
			burst_addr <= '0;
			words_left <= '0;
			beat       <= '0;
		end else begin
			status.done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (cfg.start) begin
						status.busy       <= 1'b1;
						status.errors     <= '0;
						status.first_fail <= '0;
						burst_addr        <= cfg.base;
						words_left        <= cfg.count;
						beat              <= '0;
						// empty run or no pass requested finishes at once
						if (cfg.count == '0)
							state <= S_DONE;
						else if (cfg.do_write)
							state <= S_AW;
						else if (cfg.do_verify)
							state <= S_AR;
						else
							state <= S_DONE;
					end
				end
				S_AW: begin
					if (aw_ready)
						state <= S_W;
				end
				S_W: begin
					if (w_ready) begin
						beat <= beat + 1'b1;
						if (w.last) begin
							beat  <= '0;
							state <= S_B;
						end
					end
				end
				S_B: begin
					if (b_valid) begin
						// error response charged to the burst start
						if (b_resp != ddr_test_pkg::RESP_OKAY) begin
							status.errors <= status.errors + 1'b1;
							if (status.errors == '0)
								status.first_fail <= burst_addr;
						end
						burst_addr <= burst_addr + BURST_BYTES;
						words_left <= words_left - 32'(BURST_LEN);
						if (!last_burst) begin
							state <= S_AW;
						end else if (verify_q) begin
							// rewind for the verify pass
							burst_addr <= base_q;
							words_left <= count_q;
							state      <= S_AR;
						end else begin
							state <= S_DONE;
						end
					end
				end
				S_AR: begin
					if (ar_ready)
						state <= S_R;
				end
				S_R: begin
					if (r_valid) begin
						beat <= beat + 1'b1;
						if (rd_fail) begin
							status.errors <= status.errors + 1'b1;
							if (status.errors == '0)
								status.first_fail <= beat_addr;
						end
						if (r.last) begin
							beat       <= '0;
							burst_addr <= burst_addr + BURST_BYTES;
							words_left <= words_left - 32'(BURST_LEN);
							state      <= last_burst ? S_DONE : S_AR;
						end
					end
				end
				default: begin
					status.busy <= 1'b0;
					status.done <= 1'b1;
					state       <= S_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== axi_width_upsizer.sv ====
`timescale 1ns/1ns

module axi_width_upsizer (
	input  logic                     init_calib_complete,
	input  logic                     sys_resetn,
	input  ddr_test_pkg::aw_narrow_t aw,
	input  logic                     aw_valid,
	input  logic                     aw_ready,
	input  ddr_test_pkg::ar_narrow_t ar,
	input  logic                     ar_valid,
	input  logic                     ar_ready,
	input  ddr_test_pkg::w_narrow_t  w,
	input  logic                     w_valid,
	output logic                     w_ready,
	output ddr_test_pkg::w_wide_t    w_wide,
	output logic                     w_wide_valid,
	input  logic                     w_wide_ready,
	input  ddr_test_pkg::r_wide_t    r_wide,
	input  logic                     r_wide_valid,
	output logic                     r_wide_ready,
	output ddr_test_pkg::r_narrow_t  r,
	output logic                     r_valid,
	input  logic                     r_ready
);
	localparam int NARROW     = ddr_test_pkg::NARROW_DATA_WIDTH;
	localparam int WIDE       = ddr_test_pkg::WIDE_DATA_WIDTH;
	localparam int LANE_W     = $clog2(WIDE / NARROW);
	localparam int BYTE_OFS   = $clog2(NARROW / 8);
	localparam int BEAT_BYTES = NARROW / 8;

	logic [ddr_test_pkg::ADDR_WIDTH-1:0] w_addr;
	logic [ddr_test_pkg::ADDR_WIDTH-1:0] r_addr;
	logic [LANE_W-1:0]                   w_lane;
	logic [LANE_W-1:0]                   r_lane;

	// lane is addr[3:2] for 32 on 128
	assign w_lane = w_addr[BYTE_OFS +: LANE_W];
	assign r_lane = r_addr[BYTE_OFS +: LANE_W];

	// handshakes untouched
	assign w_wide_valid = w_valid;
	assign w_ready      = w_wide_ready;
	assign r_valid      = r_wide_valid;
	assign r_wide_ready = r_ready;

	// data and strobe shifted to the lane, unused strobes stay zero
	assign w_wide = '{data: WIDE'(w.data) << (NARROW * w_lane),
			strb: (WIDE / 8)'(w.strb) << (BEAT_BYTES * w_lane), last: w.last};
	assign r = '{data: r_wide.data[NARROW * r_lane +: NARROW], resp: r_wide.resp,
			last: r_wide.last};

	// beat address per direction, reloaded by each accepted burst
	always_ff @(posedge init_calib_complete or negedge sys_resetn) begin
		if (!sys_resetn) begin
			w_addr <= '0;
			r_addr <= '0;
		end else begin
			if (aw_valid && aw_ready)
				w_addr <= aw.addr;
			else if (w_valid && w_ready)
				w_addr <= w_addr + BEAT_BYTES;
			if (ar_valid && ar_ready)
				r_addr <= ar.addr;
			else if (r_valid && r_ready)
				r_addr <= r_addr + BEAT_BYTES;
		end
	end

endmodule

// ==== axi_mem_target.sv ====
`timescale 1ns/1ns

module axi_mem_target #(
	parameter int MEM_DEPTH = 256
) (
	input  logic                     init_calib_complete,
	input  logic                     sys_resetn,
	input  ddr_test_pkg::aw_narrow_t aw,
	input  logic                     aw_valid,
	output logic                     aw_ready,
	input  ddr_test_pkg::w_wide_t    w,
	input  logic                     w_valid,
	output logic                     w_ready,
	output logic [1:0]               b_resp,
	output logic                     b_valid,
	input  logic                     b_ready,
	input  ddr_test_pkg::aw_narrow_t ar,
	input  logic                     ar_valid,
	output logic                     ar_ready,
	output ddr_test_pkg::r_wide_t    r,
	output logic                     r_valid,
	input  logic                     r_ready
);
	localparam int WIDE      = ddr_test_pkg::WIDE_DATA_WIDTH;
	localparam int ROW_W     = $clog2(MEM_DEPTH);
	localparam int ROW_SHIFT = $clog2(WIDE / 8);

	typedef enum logic [1:0] {M_IDLE, M_WRITE, M_BRESP, M_READ} state_t;

	state_t                              state;
	logic [ddr_test_pkg::ADDR_WIDTH-1:0] addr;
	logic [ddr_test_pkg::ADDR_WIDTH-1:0] step;
	logic [7:0]                          beats_left;
	logic [ROW_W-1:0]                    row;
	logic [WIDE-1:0]                     mem [MEM_DEPTH];

	// row index wraps at the array depth
	assign row = addr[ROW_SHIFT +: ROW_W];

	// one burst at a time, writes win a tie
	assign aw_ready = state == M_IDLE;
	assign ar_ready = state == M_IDLE && !aw_valid;
	assign w_ready  = state == M_WRITE;
	assign b_valid  = state == M_BRESP;
	assign b_resp   = ddr_test_pkg::RESP_OKAY;
	assign r_valid  = state == M_READ;
	assign r = '{data: mem[row], resp: ddr_test_pkg::RESP_OKAY, last: beats_left == '0};

	always_ff @(posedge init_calib_complete or negedge sys_resetn) begin
		if (!sys_resetn) begin
			state      <= M_IDLE;
			addr       <= '0;
			step       <= '0;
			beats_left <= '0;
		end else begin
			case (state)
				M_IDLE: begin
					if (aw_valid) begin
						addr  <= aw.addr;
						step  <= 32'd1 << aw.size;
						state <= M_WRITE;
					end else if (ar_valid) begin
						addr       <= ar.addr;
						step       <= 32'd1 << ar.size;
						beats_left <= ar.len;
						state      <= M_READ;
					end
				end
				M_WRITE: begin
					if (w_valid) begin
						addr <= addr + step;
						if (w.last)
							state <= M_BRESP;
					end
				end
				M_BRESP: begin
					if (b_ready)
						state <= M_IDLE;
				end
				default: begin
					// read stream pauses while r_ready is low
					if (r_ready) begin
						addr       <= addr + step;
						beats_left <= beats_left - 1'b1;
						if (beats_left == '0)
							state <= M_IDLE;
					end
				end
			endcase
		end
	end

	// byte-masked write into the current row
	always_ff @(posedge init_calib_complete) begin
		if (state == M_WRITE && w_valid) begin
			for (int i = 0; i < WIDE / 8; i++) begin
				if (w.strb[i])
					mem[row][i*8 +: 8] <= w.data[i*8 +: 8];
			end
		end
	end

endmodule

// ==== ddr_test_top.sv ====
`timescale 1ns/1ns

module ddr_test_top #(
	parameter int MEM_DEPTH = 256,
	parameter int BURST_LEN = ddr_test_pkg::BURST_LEN
) (
	input  logic                                init_calib_complete,
	input  logic                                sys_resetn,
	input  logic [ddr_test_pkg::ADDR_WIDTH-1:0] s_awaddr,
	input  logic                                s_awvalid,
	output logic                                s_awready,
	input  logic [31:0]                         s_wdata,
	input  logic [3:0]                          s_wstrb,
	input  logic                                s_wvalid,
	output logic                                s_wready,
	output logic [1:0]                          s_bresp,
	output logic                                s_bvalid,
	input  logic                                s_bready,
	input  logic [ddr_test_pkg::ADDR_WIDTH-1:0] s_araddr,
	input  logic                                s_arvalid,
	output logic                                s_arready,
	output logic [31:0]                         s_rdata,
	output logic [1:0]                          s_rresp,
	output logic                                s_rvalid,
	input  logic                                s_rready,
	output logic [2:0]                          led
);
	ddr_test_pkg::test_cfg_t    cfg;
	ddr_test_pkg::test_status_t status;
	// generator side, 32 bit
	ddr_test_pkg::aw_narrow_t   aw;
	ddr_test_pkg::ar_narrow_t   ar;
	ddr_test_pkg::w_narrow_t    w;
	ddr_test_pkg::r_narrow_t    r;
	logic aw_valid, aw_ready, ar_valid, ar_ready, w_valid, w_ready, r_valid, r_ready;
	logic [1:0] b_resp;
	logic b_valid, b_ready;
	// wide side, before and after the slices
	ddr_test_pkg::aw_narrow_t   mem_aw;
	ddr_test_pkg::w_wide_t      wide_w, mem_w;
	ddr_test_pkg::r_wide_t      wide_r, mem_r;
	logic mem_aw_valid, mem_aw_ready, wide_w_valid, wide_w_ready, mem_w_valid, mem_w_ready;
	logic wide_r_valid, wide_r_ready, mem_r_valid, mem_r_ready;

	ddr_test_regs u_regs (
		.init_calib_complete, .sys_resetn,
		.awaddr(s_awaddr), .awvalid(s_awvalid), .awready(s_awready),
		.wdata(s_wdata), .wstrb(s_wstrb), .wvalid(s_wvalid), .wready(s_wready),
		.bresp(s_bresp), .bvalid(s_bvalid), .bready(s_bready),
		.araddr(s_araddr), .arvalid(s_arvalid), .arready(s_arready),
		.rdata(s_rdata), .rresp(s_rresp), .rvalid(s_rvalid), .rready(s_rready),
		.cfg, .status, .led
	);

	ddr_traffic_gen #(.BURST_LEN(BURST_LEN)) u_gen (
		.init_calib_complete, .sys_resetn, .cfg, .status,
		.aw, .aw_valid, .aw_ready, .w, .w_valid, .w_ready,
		.b_resp, .b_valid, .b_ready, .ar, .ar_valid, .ar_ready, .r, .r_valid, .r_ready
	);

	axi_width_upsizer u_upsizer (
		.init_calib_complete, .sys_resetn,
		.aw, .aw_valid, .aw_ready, .ar, .ar_valid, .ar_ready, .w, .w_valid, .w_ready,
		.w_wide(wide_w), .w_wide_valid(wide_w_valid), .w_wide_ready(wide_w_ready),
		.r_wide(wide_r), .r_wide_valid(wide_r_valid), .r_wide_ready(wide_r_ready),
		.r, .r_valid, .r_ready
	);

	axi_reg_slice #(.payload_t(ddr_test_pkg::aw_narrow_t)) u_aw_slice (
		.init_calib_complete, .sys_resetn,
		.in(aw), .in_valid(aw_valid), .in_ready(aw_ready),
		.out(mem_aw), .out_valid(mem_aw_valid), .out_ready(mem_aw_ready)
	);

	axi_reg_slice #(.payload_t(ddr_test_pkg::w_wide_t)) u_w_slice (
		.init_calib_complete, .sys_resetn,
		.in(wide_w), .in_valid(wide_w_valid), .in_ready(wide_w_ready),
		.out(mem_w), .out_valid(mem_w_valid), .out_ready(mem_w_ready)
	);

	// read data slice runs target to upsizer
	axi_reg_slice #(.payload_t(ddr_test_pkg::r_wide_t)) u_r_slice (
		.init_calib_complete, .sys_resetn,
		.in(mem_r), .in_valid(mem_r_valid), .in_ready(mem_r_ready),
		.out(wide_r), .out_valid(wide_r_valid), .out_ready(wide_r_ready)
	);

	axi_mem_target #(.MEM_DEPTH(MEM_DEPTH)) u_mem (
		.init_calib_complete, .sys_resetn,
		.aw(mem_aw), .aw_valid(mem_aw_valid), .aw_ready(mem_aw_ready),
		.w(mem_w), .w_valid(mem_w_valid), .w_ready(mem_w_ready),
		.b_resp, .b_valid, .b_ready, .ar, .ar_valid, .ar_ready,
		.r(mem_r), .r_valid(mem_r_valid), .r_ready(mem_r_ready)
	);

endmodule

// ==== tb_ddr_test.sv ====
`timescale 1ns/1ns

module tb_ddr_test;

	// words moved per pass summed over all tests
	localparam int TOTAL_WORDS = 2 * 64 + 2 * 32 + 4 * 32 + 2 * 64;
	localparam int WATCH_CYCLES = TOTAL_WORDS * 20 + 2000;

	logic        init_calib_complete;
	logic        sys_resetn;
	logic [31:0] s_awaddr;
	logic        s_awvalid;
	logic        s_awready;
	logic [31:0] s_wdata;
	logic [3:0]  s_wstrb;
	logic        s_wvalid;
	logic        s_wready;
	logic [1:0]  s_bresp;
	logic        s_bvalid;
	logic        s_bready;
	logic [31:0] s_araddr;
	logic        s_arvalid;
	logic        s_arready;
	logic [31:0] s_rdata;
	logic [1:0]  s_rresp;
	logic        s_rvalid;
	logic        s_rready;
	logic [2:0]  led;

	int          error_count;
	int          check_count;
	int          test_count;
	logic [31:0] lcg_state;

	ddr_test_top dut (
		.init_calib_complete(init_calib_complete), .sys_resetn(sys_resetn),
		.s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
		.s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wvalid(s_wvalid), .s_wready(s_wready),
		.s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
		.s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
		.s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
		.led(led)
	);

	always #5 init_calib_complete = ~init_calib_complete;

	// numerical recipes constants
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			$display("FAIL %0t ns %s got %h expected %h", $time, name, got, expected);
			error_count++;
		end
	endtask

	// entered and left 1 ns after a rising edge
	task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		s_awaddr  = addr;
		s_awvalid = 1'b1;
		s_wdata   = data;
		s_wstrb   = 4'hf;
		s_wvalid  = 1'b1;
		// ready sampled at the falling edge before the handshake edge
		do @(negedge init_calib_complete); while (!s_awready);
		@(posedge init_calib_complete);
		#1;
		s_awvalid = 1'b0;
		s_wvalid  = 1'b0;
		s_bready  = 1'b1;
		do @(negedge init_calib_complete); while (!s_bvalid);
		resp = s_bresp;
		@(posedge init_calib_complete);
		#1;
		s_bready = 1'b0;
	endtask

	task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		s_araddr  = addr;
		s_arvalid = 1'b1;
		do @(negedge init_calib_complete); while (!s_arready);
		@(posedge init_calib_complete);
		#1;
		s_arvalid = 1'b0;
		s_rready  = 1'b1;
		do @(negedge init_calib_complete); while (!s_rvalid);
		data = s_rdata;
		resp = s_rresp;
		@(posedge init_calib_complete);
		#1;
		s_rready = 1'b0;
	endtask

	// register read that also expects OKAY
	task automatic read_ok(input logic [31:0] addr, input string name, output logic [31:0] data);
		logic [1:0] resp;
		axil_read(addr, data, resp);
		check_value({name, " rresp"}, resp, ddr_test_pkg::RESP_OKAY);
	endtask

	task automatic write_ok(input logic [31:0] addr, input string name, input logic [31:0] data);
		logic [1:0] resp;
		axil_write(addr, data, resp);
		check_value({name, " bresp"}, resp, ddr_test_pkg::RESP_OKAY);
	endtask

	task automatic configure(input logic [31:0] base, input logic [31:0] count,
			input logic [31:0] seed);
		write_ok(ddr_test_pkg::REG_BASE, "BASE", base);
		write_ok(ddr_test_pkg::REG_COUNT, "COUNT", count);
		write_ok(ddr_test_pkg::REG_SEED, "SEED", seed);
	endtask

	// poll status until the done bit shows
	task automatic wait_done();
		logic [31:0] stat;
		logic [1:0]  resp;
		do axil_read(ddr_test_pkg::REG_STATUS, stat, resp); while (!stat[1]);
	endtask

	// ctrl bit 0 requests the write pass and bit 1 the verify pass
	task automatic run_and_wait(input logic [1:0] ctrl);
		write_ok(ddr_test_pkg::REG_CTRL, "CTRL", {30'b0, ctrl});
		wait_done();
	endtask

	// expects done and idle, then the given errors and first-fail
	task automatic check_result(input logic [31:0] exp_errors, input logic [31:0] exp_first);
		logic [31:0] val;
		read_ok(ddr_test_pkg::REG_STATUS, "STATUS", val);
		check_value("STATUS", val, 32'h2);
		read_ok(ddr_test_pkg::REG_ERRORS, "ERRORS", val);
		check_value("ERRORS", val, exp_errors);
		if (exp_errors != 0) begin
			read_ok(ddr_test_pkg::REG_FIRST_FAIL, "FIRST_FAIL", val);
			check_value("FIRST_FAIL", val, exp_first);
		end
		check_value("led", {29'b0, led},
				{29'b0, exp_errors != 0, exp_errors == 0, 1'b1});
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d mismatches", name, error_count - errors_before);
	endtask

	task automatic test_reset_state();
		int          e0;
		logic [31:0] val;
		e0 = error_count;
		read_ok(ddr_test_pkg::REG_STATUS, "STATUS", val);
		check_value("STATUS", val, 32'h0);
		read_ok(ddr_test_pkg::REG_ERRORS, "ERRORS", val);
		check_value("ERRORS", val, 32'h0);
		check_value("led", {29'b0, led}, 32'h0);
		report_test("reset_state", e0);
	endtask

	task automatic test_registers();
		int          e0;
		logic [31:0] seed;
		logic [31:0] val;
		logic [1:0]  resp;
		e0   = error_count;
		seed = lcg_next();
		configure(32'h1234_5670, 32'h40, seed);
		read_ok(ddr_test_pkg::REG_BASE, "BASE", val);
		check_value("BASE", val, 32'h1234_5670);
		read_ok(ddr_test_pkg::REG_COUNT, "COUNT", val);
		check_value("COUNT", val, 32'h40);
		read_ok(ddr_test_pkg::REG_SEED, "SEED", val);
		check_value("SEED", val, seed);
		// hole past the last register
		axil_read(32'h1C, val, resp);
		check_value("rresp unmapped", resp, ddr_test_pkg::RESP_SLVERR);
		axil_read(32'h100, val, resp);
		check_value("rresp unmapped", resp, ddr_test_pkg::RESP_SLVERR);
		// no run yet, so status is idle before and after the refused write
		read_ok(ddr_test_pkg::REG_STATUS, "STATUS", val);
		check_value("STATUS", val, 32'h0);
		axil_write(ddr_test_pkg::REG_STATUS, 32'hffff_ffff, resp);
		check_value("bresp STATUS", resp, ddr_test_pkg::RESP_SLVERR);
		read_ok(ddr_test_pkg::REG_STATUS, "STATUS", val);
		check_value("STATUS", val, 32'h0);
		report_test("registers", e0);
	endtask

	task automatic test_write_verify();
		int          e0;
		logic [31:0] seed;
		e0   = error_count;
		seed = lcg_next();
		configure(32'h100, 64, seed);
		run_and_wait(2'b11);
		check_result(0, 0);
		report_test("write_verify", e0);
	endtask

	task automatic test_seed_mismatch();
		int          e0;
		logic [31:0] seed_a;
		logic [31:0] seed_b;
		logic [31:0] addr;
		logic [31:0] exp_errors;
		logic [31:0] exp_first;
		e0     = error_count;
		seed_a = lcg_next();
		seed_b = lcg_next();
		configure(32'h200, 32, seed_a);
		run_and_wait(2'b01);
		// memory holds addr^A while the verify pass expects addr^B
		exp_errors = 0;
		exp_first  = 0;
		for (int i = 0; i < 32; i++) begin
			addr = 32'h200 + 4 * i;
			if ((addr ^ seed_a) != (addr ^ seed_b)) begin
				if (exp_errors == 0)
					exp_first = addr;
				exp_errors++;
			end
		end
		write_ok(ddr_test_pkg::REG_SEED, "SEED", seed_b);
		run_and_wait(2'b10);
		check_result(exp_errors, exp_first);
		report_test("seed_mismatch", e0);
	endtask

	task automatic test_two_regions();
		int          e0;
		logic [31:0] seed_c;
		logic [31:0] seed_d;
		e0     = error_count;
		seed_c = lcg_next();
		seed_d = lcg_next();
		configure(32'h400, 32, seed_c);
		run_and_wait(2'b01);
		configure(32'h800, 32, seed_d);
		run_and_wait(2'b01);
		// first region must survive the second write
		configure(32'h400, 32, seed_c);
		run_and_wait(2'b10);
		check_result(0, 0);
		configure(32'h800, 32, seed_d);
		run_and_wait(2'b10);
		check_result(0, 0);
		report_test("two_regions", e0);
	endtask

	task automatic test_busy_ctrl();
		int          e0;
		logic [31:0] seed;
		logic [31:0] val;
		e0   = error_count;
		seed = lcg_next();
		configure(32'hC00, 64, seed);
		write_ok(ddr_test_pkg::REG_CTRL, "CTRL", 32'h3);
		// second request lands mid-run
		write_ok(ddr_test_pkg::REG_CTRL, "CTRL", 32'h1);
		read_ok(ddr_test_pkg::REG_STATUS, "STATUS", val);
		check_value("STATUS", val, 32'h1);
		wait_done();
		// a restarted run would show busy again
		repeat (20) @(posedge init_calib_complete);
		#1;
		check_result(0, 0);
		read_ok(ddr_test_pkg::REG_CTRL, "CTRL", val);
		check_value("CTRL", val, 32'h3);
		report_test("busy_ctrl", e0);
	endtask

	initial begin
		repeat (WATCH_CYCLES) @(posedge init_calib_complete);
		$display("watchdog: run did not finish within %0d cycles", WATCH_CYCLES);
		$display("tests failed");
		$finish;
	end

	initial begin
		init_calib_complete = 1'b0;
		sys_resetn          = 1'b0;
		s_awaddr            = '0;
		s_awvalid           = 1'b0;
		s_wdata             = '0;
		s_wstrb             = '0;
		s_wvalid            = 1'b0;
		s_bready            = 1'b0;
		s_araddr            = '0;
		s_arvalid           = 1'b0;
		s_rready            = 1'b0;
		error_count         = 0;
		check_count         = 0;
		test_count          = 0;
		lcg_state           = 32'h4772;
		repeat (3) @(posedge init_calib_complete);
		#1;
		sys_resetn = 1'b1;
		@(posedge init_calib_complete);
		#1;
		test_reset_state();
		test_registers();
		test_write_verify();
		test_seed_mismatch();
		test_two_regions();
		test_busy_ctrl();
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== ddr_test_top.f ====
ddr_test_pkg.sv
axi_reg_slice.sv
ddr_test_regs.sv
ddr_traffic_gen.sv
axi_width_upsizer.sv
axi_mem_target.sv
ddr_test_top.sv
tb_ddr_test.sv
